// File: Makefile
BIN  := obj_dir/Vfxd_div_unit_tb
SRCS := $(filter-out +%,$(shell cat vlog.f)) rtl/fxd_config.svh

.PHONY: run clean

# Pass only when the testbench prints the pass line
run: $(BIN)
	@out=$$(./$(BIN)); echo "$$out"; echo "$$out" | grep -qx 'sim passed'

$(BIN): vlog.f $(SRCS)
	verilator --binary --timing --assert --top-module fxd_div_unit_tb -f vlog.f

clean:
	rm -rf obj_dir

// File: rtl/fxd_config.svh
////////////////////
// Division unit configuration
// Word format and queue sizing
////////////////////
`ifndef FXD_CONFIG_SVH
`define FXD_CONFIG_SVH

`default_nettype none

// Sign-magnitude word: 1 sign bit, rest magnitude
`define FXD_WIDTH 32
// Fraction bits inside the magnitude
`define FXD_FRAC 15

// Request queue depth, also the requester's credits after reset
`define FXD_REQ_DEPTH 4
// Response queue depth
`define FXD_RSP_DEPTH 4
// Upper bound on credits the consumer may hand out
`define FXD_RSP_CREDITS 4

`default_nettype wire

`endif

// File: rtl/fxd_credit_fifo.sv
////////////////////
// Credit queue FIFO
// Circular buffer with a generic payload type
////////////////////
`timescale 1ns/1ps
`default_nettype none

module fxd_credit_fifo #(
  parameter type T     = logic,
  parameter int  DEPTH = 4
) (
  input  wire logic               clk_i,
  input  wire logic               rst_n_i,
  input  wire logic               push_i,
  input  wire T                   push_data_i,
  input  wire logic               pop_i,
  output T                        pop_data_o,
  output logic                    empty_o,
  output logic                    full_o,
  output fxd_flow_pkg::occupancy_t level_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  // Storage, payload only
  T mem_q [DEPTH];

  logic [PTR_W-1:0]         wr_ptr_q;
  logic [PTR_W-1:0]         rd_ptr_q;
  fxd_flow_pkg::occupancy_t level_q;

  // Head entry is always visible
  assign pop_data_o = mem_q[rd_ptr_q];
  assign empty_o    = (level_q == '0);
  assign full_o     = (level_q == fxd_flow_pkg::occupancy_t'(DEPTH));
  assign level_o    = level_q;

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // Pointers wrap at DEPTH, which need not be a power of two
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leave the level alone
      case ({push_i, pop_i})
        2'b10:   level_q <= level_q + 1'b1;
        2'b01:   level_q <= level_q - 1'b1;
        default: level_q <= level_q;
      endcase
    end
  end

  // Upstream must hold a credit for every push
  a_no_push_full : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> !full_o);

  // Downstream pops only a present head
  a_no_pop_empty : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> !empty_o);

endmodule

`default_nettype wire

// File: rtl/fxd_credit_sender.sv
////////////////////
// Response credit sender
////////////////////
`include "fxd_config.svh"

`timescale 1ns/1ps
`default_nettype none

module fxd_credit_sender (
  input  wire logic clk_i,
  input  wire logic rst_n_i,
  input  wire logic credit_i,
  input  wire logic avail_i,
  output logic      send_o
);

  // Slots the consumer has granted and not yet received
  fxd_flow_pkg::credit_cnt_t cnt_q;

  // Send whenever a result waits and a credit is held
  assign send_o = (cnt_q != '0) && avail_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else begin
      // Grant and send in one cycle cancel out
      case ({credit_i, send_o})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // Consumer never grants beyond its own capacity
  a_credit_max : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cnt_q <= fxd_flow_pkg::credit_cnt_t'(`FXD_RSP_CREDITS));

endmodule

`default_nettype wire

// File: rtl/fxd_div_unit.sv
////////////////////
// Queued division unit
// Credit-controlled request and response paths
////////////////////
`include "fxd_config.svh"

`timescale 1ns/1ps
`default_nettype none

module fxd_div_unit (
  input  wire logic                 clk_i,
  input  wire logic                 rst_n_i,
  input  wire logic                 req_valid_i,
  input  wire fxd_num_pkg::fx_word_t req_dividend_i,
  input  wire fxd_num_pkg::fx_word_t req_divisor_i,
  input  wire logic                 rsp_credit_i,
  output logic                      req_credit_o,
  output logic                      rsp_valid_o,
  output fxd_num_pkg::fx_word_t     rsp_quotient_o,
  output logic                      rsp_overflow_o
);

  fxd_num_pkg::div_req_t    req_push_data;
  fxd_num_pkg::div_req_t    req_head;
  logic                     req_empty;
  fxd_num_pkg::div_rsp_t    rsp_push_data;
  fxd_num_pkg::div_rsp_t    rsp_head;
  logic                     rsp_empty;
  fxd_flow_pkg::occupancy_t rsp_level;
  logic                     div_start;
  logic                     div_busy;
  logic                     div_done;
  fxd_num_pkg::fx_word_t    div_quotient;
  logic                     div_overflow;
  logic                     rsp_send;

  assign req_push_data = '{dividend: req_dividend_i, divisor: req_divisor_i};
  assign rsp_push_data = '{quotient: div_quotient, overflow: div_overflow};

  // Start needs a free response slot
  // A result being pushed this cycle already holds one
  assign div_start = !div_busy && !req_empty &&
                     ((rsp_level + fxd_flow_pkg::occupancy_t'(div_done)) <
                      fxd_flow_pkg::occupancy_t'(`FXD_RSP_DEPTH));

  // Leaving the request queue returns the requester's credit
  assign req_credit_o   = div_start;
  assign rsp_valid_o    = rsp_send;
  assign rsp_quotient_o = rsp_head.quotient;
  assign rsp_overflow_o = rsp_head.overflow;

  fxd_credit_fifo #(.T(fxd_num_pkg::div_req_t), .DEPTH(`FXD_REQ_DEPTH)) i_req_fifo (
    .clk_i, .rst_n_i,
    .push_i (req_valid_i), .push_data_i (req_push_data), .pop_i (div_start),
    .pop_data_o (req_head), .empty_o (req_empty), .full_o (), .level_o ()
  );

  fxd_serial_divider i_divider (
    .clk_i, .rst_n_i,
    .start_i (div_start), .dividend_i (req_head.dividend), .divisor_i (req_head.divisor),
    .busy_o (div_busy), .done_o (div_done),
    .quotient_o (div_quotient), .overflow_o (div_overflow)
  );

  fxd_credit_fifo #(.T(fxd_num_pkg::div_rsp_t), .DEPTH(`FXD_RSP_DEPTH)) i_rsp_fifo (
    .clk_i, .rst_n_i,
    .push_i (div_done), .push_data_i (rsp_push_data), .pop_i (rsp_send),
    .pop_data_o (rsp_head), .empty_o (rsp_empty), .full_o (), .level_o (rsp_level)
  );

  // Sender pops the response queue as it sends
  fxd_credit_sender i_sender (
    .clk_i, .rst_n_i,
    .credit_i (rsp_credit_i), .avail_i (!rsp_empty), .send_o (rsp_send)
  );

endmodule

`default_nettype wire

// File: rtl/fxd_flow_pkg.sv
////////////////////
// Flow control types
////////////////////
`include "fxd_config.svh"

`default_nettype none

package fxd_flow_pkg;

  // Counter must reach FXD_RSP_CREDITS itself, hence the +1
  localparam int CREDIT_W = $clog2(`FXD_RSP_CREDITS + 1);

  // Deepest queue in the unit sets the fill level width
  localparam int MAX_DEPTH = (`FXD_REQ_DEPTH > `FXD_RSP_DEPTH) ?
                             `FXD_REQ_DEPTH : `FXD_RSP_DEPTH;
  // Level runs from 0 up to and including the depth
  localparam int OCC_W = $clog2(MAX_DEPTH + 1);

  // Consumer credits held by the sender
  typedef logic [CREDIT_W-1:0] credit_cnt_t;

  // Queue occupancy
  typedef logic [OCC_W-1:0] occupancy_t;

endpackage

`default_nettype wire

// File: rtl/fxd_num_pkg.sv
////////////////////
// Number format types
////////////////////
`include "fxd_config.svh"

`default_nettype none

package fxd_num_pkg;

  // One fixed-point word, sign on top
  // Magnitude carries FXD_FRAC fraction bits at the bottom
  typedef struct packed {
    logic                  sign;
    logic [`FXD_WIDTH-2:0] mag;
  } fx_word_t;

  // Request queue payload
  typedef struct packed {
    fx_word_t dividend;
    fx_word_t divisor;
  } div_req_t;

  // Response queue payload
  typedef struct packed {
    fx_word_t quotient;
    logic     overflow;
  } div_rsp_t;

endpackage

`default_nettype wire

// File: rtl/fxd_serial_divider.sv
////////////////////
// Serial fixed-point divider
// One quotient bit per clock, sign-magnitude
////////////////////
`include "fxd_config.svh"

`timescale 1ns/1ps
`default_nettype none

module fxd_serial_divider (
  input  wire logic                 clk_i,
  input  wire logic                 rst_n_i,
  input  wire logic                 start_i,
  input  wire fxd_num_pkg::fx_word_t dividend_i,
  input  wire fxd_num_pkg::fx_word_t divisor_i,
  output logic                      busy_o,
  output logic                      done_o,
  output fxd_num_pkg::fx_word_t     quotient_o,
  output logic                      overflow_o
);

  // Magnitude width
  localparam int MAG_W = `FXD_WIDTH - 1;
  // Partial remainder, dividend magnitude shifted up by the fraction
  localparam int REM_W = MAG_W + `FXD_FRAC;
  // Divisor starts left-aligned one step below the top
  localparam int DVS_W = MAG_W + REM_W - 1;
  // Full quotient, top bit only set by a zero divisor
  localparam int QUO_W = REM_W + 1;
  localparam int CNT_W = $clog2(REM_W);

  logic             busy_q;
  logic             done_q;
  logic [CNT_W-1:0] cnt_q;
  logic             sign_q;
  logic [REM_W-1:0] rem_q;
  logic [DVS_W-1:0] dvs_q;
  logic [QUO_W-1:0] quo_q;

  fxd_num_pkg::fx_word_t quotient_q;
  logic                  overflow_q;

  logic             load;
  logic             last_iter;
  logic [DVS_W-1:0] rem_ext;
  logic             rem_ge;
  logic [REM_W-1:0] rem_diff;
  logic [QUO_W-1:0] quo_next;

  assign load      = !busy_q && start_i;
  assign last_iter = busy_q && (cnt_q == '0);

  // Compare and subtract step
  always_comb begin
    rem_ext  = {{(DVS_W - REM_W){1'b0}}, rem_q};
    rem_ge   = (rem_ext >= dvs_q);
    // Difference always fits when rem_ge holds
    rem_diff = REM_W'(rem_ext - dvs_q);
    quo_next = {quo_q[QUO_W-2:0], rem_ge};
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else begin
      done_q <= 1'b0;
      if (load) begin
        busy_q <= 1'b1;
        cnt_q  <= CNT_W'(REM_W - 1);
      end else if (last_iter) begin
        // Idle again in the cycle done_o is high
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end else if (busy_q) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      sign_q <= dividend_i.sign ^ divisor_i.sign;
      rem_q  <= {dividend_i.mag, {`FXD_FRAC{1'b0}}};
      dvs_q  <= {divisor_i.mag, {(REM_W - 1){1'b0}}};
      // Topmost step folded into the load
      // It only fires for a zero divisor
      quo_q  <= {{(QUO_W - 1){1'b0}}, (divisor_i.mag == '0)};
    end else if (busy_q) begin
      dvs_q <= dvs_q >> 1;
      quo_q <= quo_next;
      if (rem_ge) begin
        rem_q <= rem_diff;
      end
      if (last_iter) begin
        // Sign kept even for a zero magnitude
        quotient_q <= '{sign: sign_q, mag: quo_next[MAG_W-1:0]};
        overflow_q <= |quo_next[QUO_W-1:MAG_W];
      end
    end
  end

  assign busy_o     = busy_q;
  assign done_o     = done_q;
  assign quotient_o = quotient_q;
  assign overflow_o = overflow_q;

  // Top level must wait for idle before starting
  a_no_start_busy : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    start_i |-> !busy_o);

endmodule

`default_nettype wire

// File: tests/fxd_div_unit_tb.sv
////////////////////
// Division unit testbench
// Credit-aware requester and consumer
////////////////////
`include "fxd_config.svh"

`timescale 1ns/1ps
`default_nettype none

module fxd_div_unit_tb;

  localparam int ROWS    = 29;
  localparam int TESTS   = 5;
  localparam int TIMEOUT = 2000;
  // Cycles without a request credit that count as a stalled requester
  localparam int STALL   = 150;

  // Dividend in the upper word, divisor in the lower word
  localparam logic [63:0] STIM [ROWS] = '{
    // Sign combinations, last row is negative zero
    64'h00018000_00010000, 64'h80018000_00010000, 64'h00018000_80010000,
    64'h80008000_80018000, 64'h00000000_80010000,
    // Overflow, exactly 2^31, zero divisor
    64'h7fff0000_00000001, 64'h40000000_00004000, 64'h80028000_00000000,
    // Back to back
    64'h0012d687_00003039, 64'h7ffffffe_7fffffff, 64'h000004d2_00050000,
    64'h80007fff_00000003,
    // Consumer credits withheld
    // More rows than both queues and the divider can hold
    64'h00030000_00008000, 64'h80123456_00000777, 64'h00000001_7fffffff,
    64'h7fffffff_80000002, 64'h00a5a5a5_805a5a5a, 64'h80000000_00010000,
    64'h0000ffff_0000ffff, 64'h12345678_00abcdef, 64'h8000c000_80004000,
    64'h00054000_00002000, 64'h80001234_80005678,
    // Random credit gaps
    64'h00100000_00200000, 64'h80fedcba_00012345, 64'h3c3c3c3c_81818181,
    64'h00000100_80000100, 64'h7f00ff00_00ff00ff, 64'h80008000_00000001
  };
  localparam int FIRST [TESTS] = '{0, 5, 8, 12, 23};
  localparam int COUNT [TESTS] = '{5, 3, 4, 11, 6};
  // Consumer mode: 0 free, 1 withheld until the requester stalls, 2 random gaps
  localparam int MODE  [TESTS] = '{0, 0, 0, 1, 2};

  logic                  clk_i;
  logic                  rst_n_i;
  logic                  req_valid_i;
  fxd_num_pkg::fx_word_t req_dividend_i;
  fxd_num_pkg::fx_word_t req_divisor_i;
  logic                  rsp_credit_i;
  logic                  req_credit_o;
  logic                  rsp_valid_o;
  fxd_num_pkg::fx_word_t rsp_quotient_o;
  logic                  rsp_overflow_o;

  // Expected results in request order, read at index results
  logic [32:0] exp_q [$];
  logic [32:0] expected;
  int          sent;
  int          check_errors;
  int          mode;
  bit          released;
  bit          timed_out;
  // Owned by the monitor
  int          results       = 0;
  int          credit_pulses = 0;
  int          outstanding   = 0;
  int          rsp_errors    = 0;
  bit          grant_next    = 1'b0;

  fxd_div_unit i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Reference division taken from the number format
  function automatic logic [32:0] model_div(input logic [31:0] a, input logic [31:0] b);
    logic [63:0] num;
    logic [63:0] mag;
    logic        ovf;
    num = {33'd0, a[30:0]} << `FXD_FRAC;
    if (b[30:0] == 31'd0) begin
      // Every restoring step succeeds against a zero divisor
      mag = 64'h7fff_ffff;
      ovf = 1'b1;
    end else begin
      mag = num / {33'd0, b[30:0]};
      ovf = (mag >= 64'h8000_0000);
    end
    // Sign kept for a zero magnitude too
    return {a[31] ^ b[31], mag[30:0], ovf};
  endfunction

  // Outputs sampled mid-cycle, clear of edges and input updates
  always @(negedge clk_i) begin
    if (rst_n_i) begin
      if (req_credit_o) credit_pulses++;
      if (rsp_valid_o) begin
        outstanding--;
        if (mode == 1 && !released) begin
          $display("Result delivered while consumer credits were withheld");
          rsp_errors++;
        end
        if (results >= sent) begin
          $display("Result delivered with no request outstanding");
          rsp_errors++;
        end else begin
          expected = exp_q[results];
          if (rsp_quotient_o !== expected[32:1]) begin
            $display("ERROR rsp_quotient_o: got %h, expected %h", rsp_quotient_o, expected[32:1]);
            rsp_errors++;
          end
          if (rsp_overflow_o !== expected[0]) begin
            $display("ERROR rsp_overflow_o: got %h, expected %h", rsp_overflow_o, expected[0]);
            rsp_errors++;
          end
        end
        results++;
      end
      // Consumer grants only for results still owed, up to its capacity
      grant_next = (outstanding < `FXD_RSP_CREDITS) && (outstanding < sent - results);
      if (mode == 1 && !released) grant_next = 1'b0;
      if (mode == 2 && $urandom_range(2) != 0) grant_next = 1'b0;
      if (grant_next) outstanding++;
    end
  end

  // Consumer drives the grant picked at the previous falling edge
  initial begin
    rsp_credit_i = 1'b0;
    forever begin
      @(posedge clk_i);
      #2;
      rsp_credit_i = grant_next;
    end
  end

  // Send one table row once a request credit is held
  task automatic send_request(input int row, input int first_sent);
    int waited;
    waited = 0;
    @(posedge clk_i);
    #2;
    req_valid_i = 1'b0;
    while (`FXD_REQ_DEPTH - sent + credit_pulses == 0 && !timed_out) begin
      @(posedge clk_i);
      #2;
      waited++;
      if (mode == 1 && !released && waited == STALL) begin
        // Stalled, so every accepted request sits in a queue or the divider
        if (sent - first_sent > `FXD_REQ_DEPTH + `FXD_RSP_DEPTH + 1) begin
          $display("Requester stalled only after %0d requests", sent - first_sent);
          check_errors++;
        end
        released = 1'b1;
      end
      if (waited >= TIMEOUT) begin
        $display("Timed out waiting for a request credit");
        timed_out = 1'b1;
      end
    end
    if (!timed_out) begin
      req_valid_i    = 1'b1;
      req_dividend_i = STIM[row][63:32];
      req_divisor_i  = STIM[row][31:0];
      exp_q.push_back(model_div(STIM[row][63:32], STIM[row][31:0]));
      sent++;
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (results != sent && !timed_out) begin
      @(posedge clk_i);
      #2;
      req_valid_i = 1'b0;
      waited++;
      if (waited >= TIMEOUT) begin
        $display("Timed out waiting for outstanding results");
        timed_out = 1'b1;
      end
    end
  endtask

  initial begin
    int t;
    int r;
    int err0;
    int pulse0;
    int res0;
    int sent0;
    void'($urandom(32'h6ee7));
    sent           = 0;
    check_errors   = 0;
    mode           = 0;
    released       = 1'b0;
    timed_out      = 1'b0;
    rst_n_i        = 1'b0;
    req_valid_i    = 1'b0;
    req_dividend_i = '0;
    req_divisor_i  = '0;
    repeat (2) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;
    for (t = 0; t < TESTS && !timed_out; t++) begin
      err0     = check_errors + rsp_errors;
      pulse0   = credit_pulses;
      res0     = results;
      sent0    = sent;
      mode     = MODE[t];
      released = 1'b0;
      for (r = FIRST[t]; r < FIRST[t] + COUNT[t] && !timed_out; r++) begin
        send_request(r, sent0);
      end
      wait_drain();
      if (mode == 1 && !released) begin
        $display("Requester never stalled with consumer credits withheld");
        check_errors++;
      end
      if (credit_pulses - pulse0 != COUNT[t]) begin
        $display("ERROR req_credit_o pulses: got %h, expected %h", credit_pulses - pulse0,
                 COUNT[t]);
        check_errors++;
      end
      if (results - res0 != COUNT[t]) begin
        $display("ERROR rsp_valid_o pulses: got %h, expected %h", results - res0, COUNT[t]);
        check_errors++;
      end
      $display("test %0d: %0d requests, %0d results, %0d errors", t + 1, sent - sent0,
               results - res0, check_errors + rsp_errors - err0);
    end
    $display("%0d tests, %0d requests, %0d results, %0d errors", t, sent, results,
             check_errors + rsp_errors);
    if (check_errors + rsp_errors == 0 && !timed_out) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+rtl
rtl/fxd_num_pkg.sv
rtl/fxd_flow_pkg.sv
rtl/fxd_credit_fifo.sv
rtl/fxd_serial_divider.sv
rtl/fxd_credit_sender.sv
rtl/fxd_div_unit.sv
tests/fxd_div_unit_tb.sv
